// ==== board_glue.f ====
+incdir+include
logic/board_glue_pkg.sv
logic/spi_pad_if.sv
logic/reset_boot_ctrl.sv
logic/rtc_divider.sv
logic/fan_pwm.sv
logic/spi_pad_mux.sv
logic/board_glue_top.sv
verification/board_glue_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --assert -Wno-fatal
TOP        := board_glue_tb
RTL_TOP    := board_glue_top
FILELIST   := board_glue.f
OBJ_DIR    := obj_dir
PASS_MSG   := All tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/board_glue_patterns.txt ====
# name kind a b c d e f, hex; kind 0/1 reset by pin/probe: a=probe_sel b=sw c=probe d=boot
# 2 rtc a=half b=periods; 3 fan a=level b=high; 4 spi a=csb b=en c=sck_sd d=rnd e=miso f=dq
boot_pin_sw      0  0  2  1  2  0  0
boot_probe_vio   1  1  2  1  1  0  0
boot_pin_vio     0  1  0  3  3  0  0
boot_probe_sw    1  0  1  2  1  0  0
rtc_levels       2  19 4  0  0  0  0
fan_zero         3  0  0  0  0  0  0
fan_five         3  5  14 0  0  0  0
fan_full         3  f  3c 0  0  0  0
spi_sd_fixed     4  2  1  15 0  1  a
spi_sd_miso_low  4  2  1  0a 0  0  f
spi_sd_rand      4  2  1  0  1  1  5
spi_flash_fixed  4  1  1  0a 0  1  c
spi_flash_rand   4  1  1  0  1  1  6
spi_idle         4  3  0  1f 0  1  9
spi_off_both     4  0  0  0  0  1  3

// ==== verification/board_glue_tb.sv ====
// Board glue testbench: pattern-driven checks of reset, boot, RTC, fan PWM and SPI routing
`timescale 1ns/10ps
`include "board_glue_cfg.svh"

module board_glue_tb;
  import board_glue_pkg::*;

  localparam string pattern_file = "verification/board_glue_patterns.txt";
  localparam int    reset_cycles = 16;
  localparam int    fan_period   = (1 << `FAN_LEVEL_W) * `FAN_PRESCALE;

  logic       soc_clk, rst_n, test_mode_i, vio_reset_i, vio_boot_sel_i;
  boot_mode_t boot_mode_i, vio_boot_mode_i, boot_mode_o;
  fan_level_t fan_sw_i;
  logic       soc_spi_sck_i, soc_spi_sck_en_i;
  logic [1:0] soc_spi_csb_i, soc_spi_csb_en_i;
  spi_dq_t    soc_spi_sd_i, soc_spi_sd_en_i, soc_spi_sd_i_o;
  logic       soc_rst_n_o, rtc_o, fan_pwm_o;
  logic       sd_sclk_o, sd_cs_o, sd_cmd_o, sd_miso_i;
  logic [1:0] sd_dat_hi_o;
  logic       flash_sck_o, flash_sck_oe_o, flash_csb_o, flash_csb_oe_o;
  spi_dq_t    flash_dq_o, flash_dq_oe_o, flash_dq_i;

  // One entry per pattern line, six fields each
  string       names[$];
  int          kinds[$];
  logic [31:0] fields[$];

  int cycle_cnt   = 0;
  int cycle_limit = 0;
  int error_cnt   = 0;

  board_glue_top i_dut (.*);

  always #2 soc_clk = ~soc_clk;

  // Hang guard
  always @(posedge soc_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the run is hanging", cycle_cnt);
      fail_run();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      error_cnt++;
      $display("FAIL %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
      fail_run();
    end
  endtask

  // Outputs settle by 1 ns past the edge, new inputs go out right after
  task automatic next_cycle();
    @(posedge soc_clk);
    #1;
  endtask

  task automatic load_patterns();
    int          fd;
    string       header;
    string       name;
    int          kind;
    logic [31:0] f [6];
    fd = $fopen(pattern_file, "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file %s", pattern_file);
      fail_run();
    end
    // Two column description lines come first
    void'($fgets(header, fd));
    void'($fgets(header, fd));
    while ($fscanf(fd, "%s %h %h %h %h %h %h %h", name, kind,
                   f[0], f[1], f[2], f[3], f[4], f[5]) == 8) begin
      names.push_back(name);
      kinds.push_back(kind);
      foreach (f[k]) fields.push_back(f[k]);
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test kinds
  ////////////////////////////////////////////////////////////////////////////

  task automatic pulse_reset(input string test_name, input logic use_probe,
                             input logic probe_sel, input boot_mode_t sw_mode,
                             input boot_mode_t probe_mode, input boot_mode_t exp_mode);
    int edges;
    vio_boot_sel_i  = probe_sel;
    boot_mode_i     = sw_mode;
    vio_boot_mode_i = probe_mode;
    if (use_probe) begin
      vio_reset_i = 1'b1;
    end else begin
      rst_n = 1'b0;
    end
    #1;
    // Reset entry is asynchronous
    check_value({test_name, ".assert"}, 0, 32'(soc_rst_n_o));
    repeat (reset_cycles) begin
      next_cycle();
      check_value({test_name, ".held"}, 0, 32'(soc_rst_n_o));
      check_value({test_name, ".boot_in_reset"}, 0, 32'(boot_mode_o));
    end
    rst_n       = 1'b1;
    vio_reset_i = 1'b0;
    edges       = 0;
    while (!soc_rst_n_o && edges < 8) begin
      next_cycle();
      edges++;
    end
    check_value({test_name, ".release_edges"}, 2, edges);
    check_value({test_name, ".boot_mode"}, 32'(exp_mode), 32'(boot_mode_o));
    // Later switch or probe changes must not reach the SoC
    vio_boot_sel_i  = ~probe_sel;
    boot_mode_i     = ~exp_mode;
    vio_boot_mode_i = ~exp_mode;
    repeat (4) next_cycle();
    check_value({test_name, ".boot_hold"}, 32'(exp_mode), 32'(boot_mode_o));
  endtask

  task automatic measure_rtc(input string test_name, input int half, input int periods);
    logic level;
    int   len;
    // Level -1 only aligns to the next toggle
    for (int lvl = -1; lvl < 2 * periods; lvl++) begin
      level = rtc_o;
      len   = 0;
      while (rtc_o == level && len <= 2 * half) begin
        next_cycle();
        len++;
      end
      if (lvl >= 0) begin
        check_value($sformatf("%s.level%0d", test_name, lvl), half, len);
      end
    end
  endtask

  task automatic measure_fan(input string test_name, input fan_level_t level,
                             input int exp_high);
    int high;
    fan_sw_i = level;
    // Every full period holds one wrap, so the new level is loaded by then
    repeat (fan_period) next_cycle();
    high = 0;
    repeat (fan_period) begin
      next_cycle();
      high += int'(fan_pwm_o);
    end
    check_value({test_name, ".high_cycles"}, exp_high, high);
  endtask

  task automatic route_spi(input string test_name, input logic [1:0] csb, input logic en,
                           input logic [4:0] sck_sd, input logic rnd, input logic miso,
                           input spi_dq_t flash_in);
    logic [4:0]  drive_val;
    logic [4:0]  exp_sd;
    logic [11:0] exp_flash;
    spi_dq_t     exp_rd;
    drive_val        = rnd ? 5'($urandom) : sck_sd;
    soc_spi_sck_i    = drive_val[4];
    soc_spi_sd_i     = drive_val[3:0];
    soc_spi_sck_en_i = en;
    soc_spi_csb_i    = csb;
    soc_spi_csb_en_i = {2{en}};
    soc_spi_sd_en_i  = {4{en}};
    sd_miso_i        = miso;
    flash_dq_i       = flash_in;
    #1;
    // Driven pads follow the host, released pads idle at 1
    exp_sd    = en ? {drive_val[4], csb[0], drive_val[0], 2'b11} : 5'b11111;
    exp_flash = en ? {drive_val[4], 1'b1, csb[1], 1'b1, drive_val[3:0], 4'hf}
                   : {1'b1, 1'b0, 1'b1, 1'b0, 4'hf, 4'h0};
    check_value({test_name, ".sd_pads"}, 32'(exp_sd),
                32'({sd_sclk_o, sd_cs_o, sd_cmd_o, sd_dat_hi_o}));
    check_value({test_name, ".flash_pads"}, 32'(exp_flash),
                32'({flash_sck_o, flash_sck_oe_o, flash_csb_o, flash_csb_oe_o,
                     flash_dq_o, flash_dq_oe_o}));
    // Read data from whichever device is selected
    exp_rd = 4'h0;
    if (!csb[0]) begin
      exp_rd[1] = miso;
    end
    if (!csb[1]) begin
      exp_rd = exp_rd | flash_in;
    end
    check_value({test_name, ".read"}, 32'(exp_rd), 32'(soc_spi_sd_i_o));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int base;
    void'($urandom(32'h1ec6_1792));
    soc_clk       = 1'b0;
    rst_n         = 1'b0;
    soc_spi_csb_i = 2'b11;
    {test_mode_i, vio_reset_i, vio_boot_sel_i, boot_mode_i, vio_boot_mode_i, fan_sw_i} = '0;
    {soc_spi_sck_i, soc_spi_sck_en_i, soc_spi_csb_en_i, soc_spi_sd_i, soc_spi_sd_en_i,
     sd_miso_i, flash_dq_i} = '0;
    load_patterns();
    if (names.size() == 0) begin
      $display("No test lines found in %s", pattern_file);
      fail_run();
    end
    cycle_limit = names.size() * 200 + 100;
    foreach (names[t]) begin
      base = t * 6;
      next_cycle();
      case (kinds[t])
        0, 1: pulse_reset(names[t], kinds[t] == 1, 1'(fields[base]), 2'(fields[base + 1]),
                          2'(fields[base + 2]), 2'(fields[base + 3]));
        2: measure_rtc(names[t], int'(fields[base]), int'(fields[base + 1]));
        3: measure_fan(names[t], fan_level_t'(fields[base]), int'(fields[base + 1]));
        4: route_spi(names[t], 2'(fields[base]), 1'(fields[base + 1]), 5'(fields[base + 2]),
                     1'(fields[base + 3]), 1'(fields[base + 4]), 4'(fields[base + 5]));
        default: begin
          $display("Unknown test kind %0d in line %s", kinds[t], names[t]);
          fail_run();
        end
      endcase
    end
    if (error_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== logic/board_glue_top.sv ====
// Board glue top: reset, RTC, fan PWM and SPI pad routing between pins and SoC
`timescale 1ns/10ps

module board_glue_top (
  input  logic                       soc_clk,
  input  logic                       rst_n,
  input  logic                       test_mode_i,
  input  logic                       vio_reset_i,
  input  logic                       vio_boot_sel_i,
  input  board_glue_pkg::boot_mode_t boot_mode_i,
  input  board_glue_pkg::boot_mode_t vio_boot_mode_i,
  input  board_glue_pkg::fan_level_t fan_sw_i,

  // SoC SPI host
  input  logic                       soc_spi_sck_i,
  input  logic                       soc_spi_sck_en_i,
  input  logic [1:0]                 soc_spi_csb_i,
  input  logic [1:0]                 soc_spi_csb_en_i,
  input  board_glue_pkg::spi_dq_t    soc_spi_sd_i,
  input  board_glue_pkg::spi_dq_t    soc_spi_sd_en_i,
  output board_glue_pkg::spi_dq_t    soc_spi_sd_i_o,

  // SoC system signals
  output logic                       soc_rst_n_o,
  output logic                       rtc_o,
  output logic                       fan_pwm_o,
  output board_glue_pkg::boot_mode_t boot_mode_o,

  // SD card pads
  output logic                       sd_sclk_o,
  output logic                       sd_cs_o,
  output logic                       sd_cmd_o,
  output logic [1:0]                 sd_dat_hi_o,
  input  logic                       sd_miso_i,

  // Flash pads
  output logic                       flash_sck_o,
  output logic                       flash_sck_oe_o,
  output logic                       flash_csb_o,
  output logic                       flash_csb_oe_o,
  output board_glue_pkg::spi_dq_t    flash_dq_o,
  output board_glue_pkg::spi_dq_t    flash_dq_oe_o,
  input  board_glue_pkg::spi_dq_t    flash_dq_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Reset and boot mode
  ////////////////////////////////////////////////////////////////////////////

  reset_boot_ctrl i_reset_boot_ctrl (
    .soc_clk         ( soc_clk         ),
    .rst_n           ( rst_n           ),
    .test_mode_i     ( test_mode_i     ),
    .vio_reset_i     ( vio_reset_i     ),
    .vio_boot_sel_i  ( vio_boot_sel_i  ),
    .boot_mode_i     ( boot_mode_i     ),
    .vio_boot_mode_i ( vio_boot_mode_i ),
    .soc_rst_n_o     ( soc_rst_n_o     ),
    .boot_mode_o     ( boot_mode_o     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // RTC and fan, both held in SoC reset
  ////////////////////////////////////////////////////////////////////////////

  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk     ),
    .rst_n   ( soc_rst_n_o ),
    .rtc_o   ( rtc_o       )
  );

  fan_pwm i_fan_pwm (
    .soc_clk   ( soc_clk     ),
    .rst_n     ( soc_rst_n_o ),
    .level_i   ( fan_sw_i    ),
    .fan_pwm_o ( fan_pwm_o   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // SPI routing
  ////////////////////////////////////////////////////////////////////////////

  spi_pad_if i_spi_bus ();

  // Host side of the bundle comes from the SoC ports
  assign i_spi_bus.sck    = soc_spi_sck_i;
  assign i_spi_bus.sck_en = soc_spi_sck_en_i;
  assign i_spi_bus.csb    = soc_spi_csb_i;
  assign i_spi_bus.csb_en = soc_spi_csb_en_i;
  assign i_spi_bus.sd_out = soc_spi_sd_i;
  assign i_spi_bus.sd_en  = soc_spi_sd_en_i;
  assign soc_spi_sd_i_o   = i_spi_bus.sd_in;

  spi_pad_mux i_spi_pad_mux (
    .soc_clk        ( soc_clk        ),
    .bus            ( i_spi_bus.pads ),
    .sd_sclk_o      ( sd_sclk_o      ),
    .sd_cs_o        ( sd_cs_o        ),
    .sd_cmd_o       ( sd_cmd_o       ),
    .sd_dat_hi_o    ( sd_dat_hi_o    ),
    .sd_miso_i      ( sd_miso_i      ),
    .flash_sck_o    ( flash_sck_o    ),
    .flash_sck_oe_o ( flash_sck_oe_o ),
    .flash_csb_o    ( flash_csb_o    ),
    .flash_csb_oe_o ( flash_csb_oe_o ),
    .flash_dq_o     ( flash_dq_o     ),
    .flash_dq_oe_o  ( flash_dq_oe_o  ),
    .flash_dq_i     ( flash_dq_i     )
  );

endmodule

// ==== logic/spi_pad_mux.sv ====
// SPI pad mux: routes the SoC SPI host to the SD card and QSPI flash pads
`timescale 1ns/10ps

module spi_pad_mux (
  input  logic                    soc_clk,
  spi_pad_if.pads                 bus,

  // SD card in SPI mode, chip select 0
  output logic                    sd_sclk_o,
  output logic                    sd_cs_o,
  output logic                    sd_cmd_o,
  output logic [1:0]              sd_dat_hi_o,
  input  logic                    sd_miso_i,

  // QSPI flash, chip select 1
  output logic                    flash_sck_o,
  output logic                    flash_sck_oe_o,
  output logic                    flash_csb_o,
  output logic                    flash_csb_oe_o,
  output board_glue_pkg::spi_dq_t flash_dq_o,
  output board_glue_pkg::spi_dq_t flash_dq_oe_o,
  input  board_glue_pkg::spi_dq_t flash_dq_i
);
  import board_glue_pkg::*;

  spi_dq_t sd_src;

  ////////////////////////////////////////////////////////////////////////////
  // SD card pads
  ////////////////////////////////////////////////////////////////////////////

  // Pads idle high whenever the host is not driving them
  assign sd_sclk_o = bus.sck_en    ? bus.sck       : 1'b1;
  assign sd_cs_o   = bus.csb_en[0] ? bus.csb[0]    : 1'b1;
  assign sd_cmd_o  = bus.sd_en[0]  ? bus.sd_out[0] : 1'b1;

  // DAT1 and DAT2 are unused in SPI mode
  assign sd_dat_hi_o = 2'b11;

  // Card data out lands on host lane 1
  assign sd_src = {2'b00, sd_miso_i, 1'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Flash pads
  ////////////////////////////////////////////////////////////////////////////

  assign flash_sck_o    = bus.sck_en    ? bus.sck    : 1'b1;
  assign flash_sck_oe_o = bus.sck_en;
  assign flash_csb_o    = bus.csb_en[1] ? bus.csb[1] : 1'b1;
  assign flash_csb_oe_o = bus.csb_en[1];

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      flash_dq_o[i] = bus.sd_en[i] ? bus.sd_out[i] : 1'b1;
    end
  end

  assign flash_dq_oe_o = bus.sd_en;

  ////////////////////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////////////////////

  // Active-low chip select picks which device answers
  assign bus.sd_in = ({4{~bus.csb[0]}} & sd_src) |
                     ({4{~bus.csb[1]}} & flash_dq_i);

  // Host must never select both devices at the same time
  a_one_cs_active : assert property (
    @(posedge soc_clk)
    !((bus.csb_en[0] && !bus.csb[0]) && (bus.csb_en[1] && !bus.csb[1]))
  );

endmodule

// ==== logic/fan_pwm.sv ====
// Fan PWM: prescaled phase counter compared against the latched switch setting
`timescale 1ns/10ps
`include "board_glue_cfg.svh"

module fan_pwm (
  input  logic                       soc_clk,
  input  logic                       rst_n,
  input  board_glue_pkg::fan_level_t level_i,
  output logic                       fan_pwm_o
);
  import board_glue_pkg::*;

  localparam int unsigned PrescW = $clog2(`FAN_PRESCALE);
  localparam int unsigned Period = (1 << `FAN_LEVEL_W) * `FAN_PRESCALE;

  logic [PrescW-1:0] presc_q;
  fan_level_t        phase_q;
  fan_level_t        level_q;
  logic              step;
  logic              wrap;

  ////////////////////////////////////////////////////////////////////////////
  // Prescaler and phase
  ////////////////////////////////////////////////////////////////////////////

  assign step = (presc_q == PrescW'(`FAN_PRESCALE - 1));
  // Phase about to roll over to 0
  assign wrap = step && (phase_q == '1);

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
      phase_q <= '0;
    end else begin
      presc_q <= step ? '0 : presc_q + 1'b1;
      if (step) begin
        phase_q <= phase_q + 1'b1;
      end
    end
  end

  // Setting only changes at a period start, so no mid-period glitch
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      level_q <= '0;
    end else if (wrap) begin
      level_q <= level_i;
    end
  end

  assign fan_pwm_o = (phase_q < level_q);

  // A zero setting keeps the fan off for the whole next period
  a_level_zero_low : assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (wrap && level_i == '0) |=> !fan_pwm_o [*Period]
  );

endmodule

// ==== logic/rtc_divider.sv ====
// RTC divider: turns soc_clk into a slow real-time-clock level
`timescale 1ns/10ps
`include "board_glue_cfg.svh"

module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  localparam logic [`RTC_CNT_W-1:0] CntMax = `RTC_CNT_W'(`RTC_HALF_PERIOD - 1);

  logic [`RTC_CNT_W-1:0] cnt_d, cnt_q;
  logic                  rtc_d, rtc_q;

  ////////////////////////////////////////////////////////////////////////////
  // Half-period counter
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q + 1'b1;
    rtc_d = rtc_q;
    // Last cycle of the half period
    if (cnt_q == CntMax) begin
      cnt_d = '0;
      rtc_d = ~rtc_q;
    end
  end

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      rtc_q <= rtc_d;
    end
  end

  assign rtc_o = rtc_q;

  // Counter wraps before passing the half period
  a_cnt_in_range : assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    cnt_q <= CntMax
  );

endmodule

// ==== logic/reset_boot_ctrl.sv ====
// Reset control: merges board and probe resets, syncs release, latches boot mode
`timescale 1ns/10ps

module reset_boot_ctrl (
  input  logic                    soc_clk,
  input  logic                    rst_n,
  input  logic                    test_mode_i,
  input  logic                    vio_reset_i,
  input  logic                    vio_boot_sel_i,
  input  board_glue_pkg::boot_mode_t boot_mode_i,
  input  board_glue_pkg::boot_mode_t vio_boot_mode_i,
  output logic                    soc_rst_n_o,
  output board_glue_pkg::boot_mode_t boot_mode_o
);

  logic       rst_int_n;
  logic [1:0] sync_q;
  logic       release_edge;

  // Board reset or probe reset pulls the SoC into reset
  assign rst_int_n = rst_n & ~vio_reset_i;

  // Assert asynchronously, release after two flops
  always_ff @(posedge soc_clk or negedge rst_int_n) begin
    if (!rst_int_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Test mode hands the pin reset straight through
  assign soc_rst_n_o = test_mode_i ? rst_n : sync_q[1];

  // High for the one cycle before the synchronized reset lifts
  assign release_edge = sync_q[0] & ~sync_q[1];

  always_ff @(posedge soc_clk or negedge rst_int_n) begin
    if (!rst_int_n) begin
      boot_mode_o <= '0;
    end else if (release_edge) begin
      boot_mode_o <= vio_boot_sel_i ? vio_boot_mode_i : boot_mode_i;
    end
  end

  // Boot mode holds for as long as the SoC stays out of reset
  a_boot_mode_stable : assert property (
    @(posedge soc_clk) disable iff (!soc_rst_n_o || test_mode_i)
    $past(soc_rst_n_o) |-> $stable(boot_mode_o)
  );

endmodule

// ==== logic/spi_pad_if.sv ====
// SPI pad interface: SoC SPI host signals on their way to the board pads
`timescale 1ns/10ps
`include "board_glue_cfg.svh"

interface spi_pad_if;
  import board_glue_pkg::*;

  // Host side outputs
  logic                   sck;
  logic                   sck_en;
  logic [`SPI_NUM_CS-1:0] csb;
  logic [`SPI_NUM_CS-1:0] csb_en;
  spi_dq_t                sd_out;
  spi_dq_t                sd_en;

  // Read data back to the host
  spi_dq_t                sd_in;

  modport host (
    output sck, sck_en, csb, csb_en, sd_out, sd_en,
    input  sd_in
  );

  modport pads (
    input  sck, sck_en, csb, csb_en, sd_out, sd_en,
    output sd_in
  );

endinterface

// ==== logic/board_glue_pkg.sv ====
// Board glue package: shared types for boot mode, fan level and SPI data lanes
`include "board_glue_cfg.svh"

package board_glue_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Boot and fan
  ////////////////////////////////////////////////////////////////////////////

  // Boot source code handed to the SoC
  typedef logic [1:0] boot_mode_t;

  // Fan duty setting from the switches
  typedef logic [`FAN_LEVEL_W-1:0] fan_level_t;

  ////////////////////////////////////////////////////////////////////////////
  // SPI
  ////////////////////////////////////////////////////////////////////////////

  // One bit per quad SPI data lane
  typedef logic [3:0] spi_dq_t;

endpackage

// ==== include/board_glue_cfg.svh ====
// Board glue configuration: divider, PWM and SPI sizing constants
`ifndef BOARD_GLUE_CFG_SVH
`define BOARD_GLUE_CFG_SVH

// soc_clk cycles per RTC half period
// 50 MHz / (2 * 25) gives a 1 MHz RTC level
`define RTC_HALF_PERIOD 25

// Width of the RTC cycle counter
`define RTC_CNT_W 16

// Fan duty setting width, one step per switch code
`define FAN_LEVEL_W 4

// soc_clk cycles per PWM phase step
`define FAN_PRESCALE 4

// Chip selects on the SoC SPI host
`define SPI_NUM_CS 2

`endif
